//--- src.f
+incdir+verification
hw/tab_pkg.sv
hw/beat_timer.sv
hw/fret_capture.sv
hw/tab_memory.sv
hw/mode_control.sv
hw/note_display.sv
hw/tab_recorder_top.sv
verification/tb_tab_recorder.sv

//--- Makefile
SIM      := verilator
TOP      := tb_tab_recorder
FILELIST := src.f
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
PASS_MSG := TESTBENCH PASSED
SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard verification/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verification/tb_tab_checks.svh
// tab recorder checks
`ifndef TB_TAB_CHECKS_SVH
`define TB_TAB_CHECKS_SVH

	////////////////////////////////////////////////////////////
	// note path
	////////////////////////////////////////////////////////////
	a_beat: assert property (@(posedge clk) disable iff (!resetn) beat == exp_beat)
		else stop_on_mismatch($sformatf("beat is %0b, expected %0b", beat, exp_beat));

	// live word while recording, stored word while playing, else zero
	a_note: assert property (@(posedge clk) disable iff (!resetn) note_out == exp_note_out)
		else stop_on_mismatch($sformatf("note_out %h, expected %h", note_out, exp_note_out));

	////////////////////////////////////////////////////////////
	// controller
	////////////////////////////////////////////////////////////
	a_state: assert property (@(posedge clk) disable iff (!resetn) state_code == exp_state)
		else stop_on_mismatch($sformatf("state_code %0d, expected %0d", state_code, exp_state));

	////////////////////////////////////////////////////////////
	// display
	////////////////////////////////////////////////////////////
	a_hex0: assert property (@(posedge clk) disable iff (!resetn)
		hex0 == tab_pkg::SEG_TABLE[digit_of(exp_note_out[15:0])]
	) else stop_on_mismatch($sformatf("hex0 %b for note %h", hex0, exp_note_out));

	a_hex1: assert property (@(posedge clk) disable iff (!resetn)
		hex1 == tab_pkg::SEG_TABLE[digit_of(exp_note_out[31:16])]
	) else stop_on_mismatch($sformatf("hex1 %b for note %h", hex1, exp_note_out));

	a_hex4: assert property (@(posedge clk) disable iff (!resetn)
		hex4 == tab_pkg::SEG_TABLE[exp_state]
	) else stop_on_mismatch($sformatf("hex4 %b in state %0d", hex4, exp_state));

	a_hex5: assert property (@(posedge clk) disable iff (!resetn)
		hex5 == tab_pkg::SEG_TABLE[{3'b000, exp_state[3]}]         // msb only
	) else stop_on_mismatch($sformatf("hex5 %b in state %0d", hex5, exp_state));

`endif

//--- verification/tb_tab_recorder.sv
`timescale 1ns/1ns
// tab recorder testbench
module tb_tab_recorder;

	localparam int PERIODS [8] = '{60, 40, 30, 24, 20, 17, 13, 10};  // 2400 / bpm
	localparam int LIMIT = 64 * 60 * 3 + 2000;

	logic clk, resetn, select, back, mode_sw, beat;
	logic [5:0]  strings;
	logic [3:0]  frets;
	logic [2:0]  tempo_sw;
	logic [31:0] note_out;
	logic [3:0]  state_code;
	logic [6:0]  hex0, hex1, hex4, hex5;

	// reference model
	tab_pkg::mode_state_t exp_state, exp_next;
	logic [31:0] exp_word, exp_play_note, exp_note_out;
	logic [31:0] mem_m [64];
	logic [5:0]  acc_str, exp_addr;
	logic        exp_beat, exp_strobe, exp_record, exp_play, exp_clear;
	int          acc_pos, cur_pos, since, period_m, notes_done;
	int          cycles = 0;

	tab_recorder_top #(.CLKS_PER_MINUTE(2400)) DUT (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// highest bar pressed, 0 when open
	function automatic int bar_pos(input logic [3:0] f);
		int p;
		p = 0;
		for (int i = 0; i < 4; i++)
			if (f[i])
				p = i + 1;
		return p;
	endfunction

	function automatic logic [31:0] encode(input logic [5:0] s, input int pos);
		logic [31:0] w;
		w = '0;
		for (int i = 0; i < 6; i++)
			w[pos * 6 + i] = s[i];
		return w;
	endfunction

	// hex digit of a display half, F unless exactly one bit
	function automatic int digit_of(input logic [15:0] half);
		return ($countones(half) == 1) ? $clog2(half) : 15;
	endfunction

	task automatic stop_on_mismatch(input string what);
		$display("Mismatch at %0t ns: %s", $time, what);
		$display("TESTBENCH FAILED");
		$fatal(1, "check failed");
	endtask

	////////////////////////////////////////////////////////////
	// expected behaviour
	////////////////////////////////////////////////////////////
	assign exp_beat     = (since == period_m);
	assign exp_record   = exp_state inside {tab_pkg::ST_RECORDING, tab_pkg::ST_RECORDING_REL};
	assign exp_play     = exp_state inside {tab_pkg::ST_PLAYING, tab_pkg::ST_PLAYING_REL};
	assign exp_clear    = exp_state inside {tab_pkg::ST_WAIT_REC, tab_pkg::ST_WAIT_REC_REL,
	                                        tab_pkg::ST_WAIT_PLAY, tab_pkg::ST_WAIT_PLAY_REL};
	assign exp_note_out = exp_record ? exp_word : exp_play ? exp_play_note : '0;
	assign cur_pos      = (bar_pos(frets) > acc_pos) ? bar_pos(frets) : acc_pos;

	always @(posedge clk) begin
		if (!resetn) begin
			since <= 1;
			period_m <= PERIODS[tempo_sw];
			exp_state <= tab_pkg::ST_SELECT;
			{exp_word, exp_play_note, acc_str, exp_addr, exp_strobe} <= '0;
			acc_pos <= 0;
			notes_done <= 0;
		end else begin
			exp_state <= exp_next;
			exp_strobe <= exp_beat;                 // word follows one cycle after beat
			since <= exp_beat ? 1 : since + 1;
			if (exp_beat) begin
				period_m <= PERIODS[tempo_sw];
				exp_word <= encode(acc_str | strings, cur_pos);
				acc_str <= '0;
				acc_pos <= 0;
			end else begin
				acc_str <= acc_str | strings;
				acc_pos <= cur_pos;
			end
			if (exp_clear) begin
				{exp_addr, exp_play_note} <= '0;
				notes_done <= 0;
			end else if (exp_strobe && (exp_record || exp_play)) begin
				exp_addr <= exp_addr + 1'b1;
				notes_done <= notes_done + 1;
				if (exp_record)
					mem_m[exp_addr] <= exp_word;
				else
					exp_play_note <= mem_m[exp_addr];
			end
		end
	end

	`include "tb_tab_checks.svh"

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", LIMIT);
			$display("TESTBENCH FAILED");
			$fatal(1, "timeout");
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////
	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	// buttons for one cycle, and the state they lead to
	task automatic buttons(input logic sel, input logic bk, input tab_pkg::mode_state_t nxt);
		select = sel;
		back = bk;
		exp_next = nxt;
		next_cycle();
	endtask

	task automatic wait_beat();
		do
			next_cycle();
		while (!beat);
	endtask

	task automatic drive_random();
		int r;
		r = $urandom % 16;
		if (r == 0)
			strings = 6'($urandom);                 // chord
		else if (r == 1)
			strings = 6'(1 << ($urandom % 6));      // single string
		else if (r > 3)
			strings = '0;                           // 2 and 3 hold the last value
		if ($urandom % 8 == 0)
			frets = 4'($urandom);
		next_cycle();
	endtask

	task automatic enter_wait(input logic rec);
		mode_sw = rec;
		buttons(1'b1, 1'b0, tab_pkg::ST_SELECT_REL);
		buttons(1'b1, 1'b0, tab_pkg::ST_SELECT_REL);
		buttons(1'b0, 1'b0, rec ? tab_pkg::ST_WAIT_REC : tab_pkg::ST_WAIT_PLAY);
	endtask

	// record or play n notes, then stop and return to select
	task automatic run_notes(input logic rec, input int n);
		enter_wait(rec);
		buttons(1'b1, 1'b0, rec ? tab_pkg::ST_WAIT_REC_REL : tab_pkg::ST_WAIT_PLAY_REL);
		buttons(1'b0, 1'b0, rec ? tab_pkg::ST_RECORDING : tab_pkg::ST_PLAYING);
		while (notes_done < n)
			drive_random();
		buttons(1'b1, 1'b0, rec ? tab_pkg::ST_RECORDING_REL : tab_pkg::ST_PLAYING_REL);
		buttons(1'b0, 1'b0, rec ? tab_pkg::ST_REC_STOP : tab_pkg::ST_PLAY_STOP);
		buttons(!rec, rec, rec ? tab_pkg::ST_REC_STOP_REL : tab_pkg::ST_PLAY_STOP_REL);
		buttons(1'b0, 1'b0, tab_pkg::ST_SELECT);
	endtask

	initial begin
		void'($urandom(79));
		{resetn, select, back, mode_sw, tempo_sw, strings, frets} <= '0;
		exp_next = tab_pkg::ST_SELECT;
		repeat (3) @(posedge clk);
		#2 resetn = 1'b1;
		for (int t = 0; t < 8; t++) begin
			tempo_sw = 3'(t);
			repeat (3) wait_beat();
		end
		enter_wait(1'b1);                           // back out of both wait states
		buttons(1'b0, 1'b1, tab_pkg::ST_SELECT);
		buttons(1'b0, 1'b0, tab_pkg::ST_SELECT);
		enter_wait(1'b0);
		buttons(1'b0, 1'b1, tab_pkg::ST_SELECT);
		buttons(1'b0, 1'b0, tab_pkg::ST_SELECT);
		tempo_sw = 3'd4;
		run_notes(1'b1, 20);
		run_notes(1'b0, 20);
		tempo_sw = 3'd7;
		run_notes(1'b1, 70);                        // wraps the address
		run_notes(1'b0, 70);
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

//--- hw/tab_recorder_top.sv
`timescale 1ns/1ns
// tab recorder top
module tab_recorder_top #(
	parameter longint unsigned CLKS_PER_MINUTE = 64'd3_000_000_000
) (
	input  logic                            clk,
	input  logic                            resetn,
	input  logic [tab_pkg::NUM_STRINGS-1:0] strings,
	input  logic [tab_pkg::NUM_FRETS-1:0]   frets,
	input  logic                            select,
	input  logic                            back,
	input  logic                            mode_sw,
	input  logic [2:0]                      tempo_sw,
	output logic                            beat,
	output logic [tab_pkg::NOTE_W-1:0]      note_out,
	output logic [3:0]                      state_code,
	output logic [tab_pkg::SEG_W-1:0]       hex0,
	output logic [tab_pkg::SEG_W-1:0]       hex1,
	output logic [tab_pkg::SEG_W-1:0]       hex4,
	output logic [tab_pkg::SEG_W-1:0]       hex5
);

	logic [tab_pkg::NOTE_W-1:0] note_word;
	logic [tab_pkg::NOTE_W-1:0] play_note;
	logic                       note_strobe;
	logic                       is_record;
	logic                       is_play;
	logic                       addr_clear;

	////////////////////////////////////////////////////////////
	// note path
	////////////////////////////////////////////////////////////
	beat_timer #(.CLKS_PER_MINUTE(CLKS_PER_MINUTE)) u_beat_timer (
		.clk(clk), .resetn(resetn), .tempo_sw(tempo_sw), .beat(beat)
	);

	fret_capture u_fret_capture (
		.clk(clk), .resetn(resetn), .beat(beat), .strings(strings), .frets(frets),
		.note_word(note_word), .note_strobe(note_strobe)
	);

	tab_memory u_tab_memory (
		.clk(clk), .resetn(resetn), .note_strobe(note_strobe), .note_word(note_word),
		.is_record(is_record), .is_play(is_play), .addr_clear(addr_clear),
		.play_note(play_note)
	);

	////////////////////////////////////////////////////////////
	// control and display
	////////////////////////////////////////////////////////////
	mode_control u_mode_control (
		.clk(clk), .resetn(resetn), .select(select), .back(back), .mode_sw(mode_sw),
		.is_record(is_record), .is_play(is_play), .addr_clear(addr_clear),
		.state_code(state_code)
	);

	// live note while recording, stored note while playing
	assign note_out = is_record ? note_word :
	                  is_play   ? play_note : '0;

	note_display u_note_display (
		.note_out(note_out), .state_code(state_code),
		.hex0(hex0), .hex1(hex1), .hex4(hex4), .hex5(hex5)
	);

endmodule

//--- hw/note_display.sv
`timescale 1ns/1ns
// note and state seven segment display
module note_display (
	input  logic [tab_pkg::NOTE_W-1:0] note_out,
	input  logic [3:0]                 state_code,
	output logic [tab_pkg::SEG_W-1:0]  hex0,
	output logic [tab_pkg::SEG_W-1:0]  hex1,
	output logic [tab_pkg::SEG_W-1:0]  hex4,
	output logic [tab_pkg::SEG_W-1:0]  hex5
);

	localparam int HALF_W = tab_pkg::NOTE_W / 2;

	logic [3:0] lo_digit;
	logic [3:0] hi_digit;
	logic [3:0] top_digit;

	// position of the single set bit, F when none or several
	function automatic logic [3:0] onehot_digit(input logic [HALF_W-1:0] half);
		logic [3:0] digit;
		digit = 4'hF;
		if ($onehot(half)) begin
			for (int i = 0; i < HALF_W; i++) begin
				if (half[i])
					digit = 4'(i);
			end
		end
		return digit;
	endfunction

	////////////////////////////////////////////////////////////
	// digit selection
	////////////////////////////////////////////////////////////
	assign lo_digit  = onehot_digit(note_out[HALF_W-1:0]);
	assign hi_digit  = onehot_digit(note_out[tab_pkg::NOTE_W-1:HALF_W]);
	assign top_digit = {3'b000, state_code[3]};    // msb of the state

	// segment lookup
	assign hex0 = tab_pkg::SEG_TABLE[lo_digit];
	assign hex1 = tab_pkg::SEG_TABLE[hi_digit];
	assign hex4 = tab_pkg::SEG_TABLE[state_code];
	assign hex5 = tab_pkg::SEG_TABLE[top_digit];

endmodule

//--- hw/mode_control.sv
`timescale 1ns/1ns
// mode controller FSM
module mode_control (
	input  logic       clk,
	input  logic       resetn,
	input  logic       select,
	input  logic       back,
	input  logic       mode_sw,     // 1 record, 0 play
	output logic       is_record,
	output logic       is_play,
	output logic       addr_clear,
	output logic [3:0] state_code
);

	tab_pkg::mode_state_t state;
	tab_pkg::mode_state_t next_state;

	////////////////////////////////////////////////////////////
	// next state
	////////////////////////////////////////////////////////////
	always_comb begin
		next_state = state;
		case (state)
			tab_pkg::ST_SELECT:
				if (select)
					next_state = tab_pkg::ST_SELECT_REL;
			tab_pkg::ST_SELECT_REL:
				if (!select)
					next_state = mode_sw ? tab_pkg::ST_WAIT_REC : tab_pkg::ST_WAIT_PLAY;

			// record path
			tab_pkg::ST_WAIT_REC:
				if (back)
					next_state = tab_pkg::ST_SELECT;
				else if (select)
					next_state = tab_pkg::ST_WAIT_REC_REL;
			tab_pkg::ST_WAIT_REC_REL:
				if (!select)
					next_state = tab_pkg::ST_RECORDING;
			tab_pkg::ST_RECORDING:
				if (select)
					next_state = tab_pkg::ST_RECORDING_REL;
			tab_pkg::ST_RECORDING_REL:
				if (!select)
					next_state = tab_pkg::ST_REC_STOP;
			tab_pkg::ST_REC_STOP:
				if (select | back)
					next_state = tab_pkg::ST_REC_STOP_REL;
			tab_pkg::ST_REC_STOP_REL:
				if (!(select | back))
					next_state = tab_pkg::ST_SELECT;

			// play path
			tab_pkg::ST_WAIT_PLAY:
				if (back)
					next_state = tab_pkg::ST_SELECT;
				else if (select)
					next_state = tab_pkg::ST_WAIT_PLAY_REL;
			tab_pkg::ST_WAIT_PLAY_REL:
				if (!select)
					next_state = tab_pkg::ST_PLAYING;
			tab_pkg::ST_PLAYING:
				if (select)
					next_state = tab_pkg::ST_PLAYING_REL;
			tab_pkg::ST_PLAYING_REL:
				if (!select)
					next_state = tab_pkg::ST_PLAY_STOP;
			tab_pkg::ST_PLAY_STOP:
				if (select | back)
					next_state = tab_pkg::ST_PLAY_STOP_REL;
			tab_pkg::ST_PLAY_STOP_REL:
				if (!(select | back))
					next_state = tab_pkg::ST_SELECT;

			default: next_state = tab_pkg::ST_SELECT;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			state <= tab_pkg::ST_SELECT;
		else
			state <= next_state;
	end

	////////////////////////////////////////////////////////////
	// state decode
	////////////////////////////////////////////////////////////
	assign addr_clear = (state == tab_pkg::ST_WAIT_REC)  || (state == tab_pkg::ST_WAIT_REC_REL) ||
	                    (state == tab_pkg::ST_WAIT_PLAY) || (state == tab_pkg::ST_WAIT_PLAY_REL);
	assign is_record  = (state == tab_pkg::ST_RECORDING) || (state == tab_pkg::ST_RECORDING_REL);
	assign is_play    = (state == tab_pkg::ST_PLAYING)   || (state == tab_pkg::ST_PLAYING_REL);
	assign state_code = state;

	a_state_legal: assert property (
		@(posedge clk) disable iff (!resetn)
		state inside {[tab_pkg::ST_SELECT : tab_pkg::ST_PLAY_STOP_REL]}
	) else $error("mode state outside the legal range");

endmodule

//--- hw/tab_memory.sv
`timescale 1ns/1ns
// note memory
module tab_memory (
	input  logic                       clk,
	input  logic                       resetn,
	input  logic                       note_strobe,
	input  logic [tab_pkg::NOTE_W-1:0] note_word,
	input  logic                       is_record,
	input  logic                       is_play,
	input  logic                       addr_clear,
	output logic [tab_pkg::NOTE_W-1:0] play_note
);

	localparam int DEPTH = 2 ** tab_pkg::ADDR_W;

	logic [tab_pkg::NOTE_W-1:0] mem [DEPTH];
	logic [tab_pkg::ADDR_W-1:0] addr;
	logic                       wr_en;
	logic                       rd_en;

	assign wr_en = note_strobe & is_record;
	assign rd_en = note_strobe & is_play;

	////////////////////////////////////////////////////////////
	// address counter, wraps at 64
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!resetn) begin
			addr <= '0;
		end else if (addr_clear) begin
			addr <= '0;
		end else if (wr_en | rd_en) begin
			addr <= addr + 1'b1;
		end
	end

	// ram array
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[addr] <= note_word;
	end

	// registered read, valid the cycle after the strobe
	always_ff @(posedge clk) begin
		if (!resetn) begin
			play_note <= '0;
		end else if (addr_clear) begin
			play_note <= '0;                        // nothing shown before first beat
		end else if (rd_en) begin
			play_note <= mem[addr];
		end
	end

	a_mode_excl: assert property (
		@(posedge clk) disable iff (!resetn) !(is_record && is_play)
	) else $error("record and play active together");

endmodule

//--- hw/fret_capture.sv
`timescale 1ns/1ns
// string and fret capture
module fret_capture (
	input  logic                            clk,
	input  logic                            resetn,
	input  logic                            beat,
	input  logic [tab_pkg::NUM_STRINGS-1:0] strings,
	input  logic [tab_pkg::NUM_FRETS-1:0]   frets,
	output logic [tab_pkg::NOTE_W-1:0]      note_word,
	output logic                            note_strobe
);

	localparam int NUM_POS = tab_pkg::NUM_FRETS + 1;    // open plus four bars
	localparam int POS_W   = $clog2(NUM_POS);

	logic [tab_pkg::NUM_STRINGS-1:0] str_acc;
	logic [tab_pkg::NUM_STRINGS-1:0] str_now;
	logic [POS_W-1:0]                pos_acc;
	logic [POS_W-1:0]                pos_in;
	logic [POS_W-1:0]                pos_now;
	logic [tab_pkg::NOTE_W-1:0]      enc;
	logic [NUM_POS-1:0]              grp_set;

	// highest bar pressed this cycle, 0 when open
	always_comb begin
		pos_in = '0;
		for (int i = 0; i < tab_pkg::NUM_FRETS; i++) begin
			if (frets[i])
				pos_in = POS_W'(i + 1);
		end
	end

	// include the current cycle, so the beat cycle itself counts
	assign str_now = str_acc | strings;
	assign pos_now = (pos_in > pos_acc) ? pos_in : pos_acc;

	////////////////////////////////////////////////////////////
	// one-hot note encoding
	////////////////////////////////////////////////////////////
	always_comb begin
		enc = '0;
		enc[pos_now * tab_pkg::NUM_STRINGS +: tab_pkg::NUM_STRINGS] = str_now;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			str_acc     <= '0;
			pos_acc     <= '0;
			note_word   <= '0;
			note_strobe <= 1'b0;
		end else if (beat) begin
			note_word   <= enc;
			note_strobe <= 1'b1;
			str_acc     <= '0;                      // fresh window for next beat
			pos_acc     <= '0;
		end else begin
			str_acc     <= str_now;
			pos_acc     <= pos_now;
			note_strobe <= 1'b0;
		end
	end

	// which fret groups carry any string
	for (genvar g = 0; g < NUM_POS; g++) begin : g_grp
		assign grp_set[g] = |note_word[g * tab_pkg::NUM_STRINGS +: tab_pkg::NUM_STRINGS];
	end

	a_note_shape: assert property (
		@(posedge clk) disable iff (!resetn)
		$onehot0(grp_set) && (note_word[tab_pkg::NOTE_W-1 -: 2] == 2'b00)
	) else $error("note word has several fret groups or top bits set");

endmodule

//--- hw/beat_timer.sv
`timescale 1ns/1ns
// beat tempo timer
module beat_timer #(
	parameter longint unsigned CLKS_PER_MINUTE = 64'd3_000_000_000
) (
	input  logic       clk,
	input  logic       resetn,
	input  logic [2:0] tempo_sw,
	output logic       beat
);

	// table entry 0 is the slowest tempo, so it sets the counter width
	localparam longint unsigned MAX_PERIOD = CLKS_PER_MINUTE / tab_pkg::TEMPO_BPM[0];
	localparam int CNT_W = $clog2(MAX_PERIOD + 1);

	logic [CNT_W-1:0] period_tbl [tab_pkg::NUM_TEMPOS];
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] reload;

	////////////////////////////////////////////////////////////
	// period lookup, clocks per beat rounded down
	////////////////////////////////////////////////////////////
	for (genvar i = 0; i < tab_pkg::NUM_TEMPOS; i++) begin : g_period
		assign period_tbl[i] = CNT_W'(CLKS_PER_MINUTE / tab_pkg::TEMPO_BPM[i]);
	end

	assign reload = period_tbl[tempo_sw] - 1'b1;   // new tempo only seen here

	assign beat = (count == '0);

	////////////////////////////////////////////////////////////
	// down counter
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!resetn) begin
			count <= reload;
		end else if (beat) begin
			count <= reload;                        // start next period
		end else begin
			count <= count - 1'b1;
		end
	end

	// one clean pulse per period
	a_beat_single: assert property (
		@(posedge clk) disable iff (!resetn) beat |=> !beat
	) else $error("beat high on two consecutive cycles");

endmodule

//--- hw/tab_pkg.sv
// tab recorder shared definitions
package tab_pkg;

	localparam int NUM_STRINGS = 6;
	localparam int NUM_FRETS   = 4;      // bars 1..4, position 0 is open
	localparam int NOTE_W      = 32;     // bit = fret position * 6 + string
	localparam int ADDR_W      = 6;      // 64 notes
	localparam int SEG_W       = 7;      // active low segments
	localparam int NUM_TEMPOS  = 8;

	// beats per minute, slowest first
	localparam int unsigned TEMPO_BPM [NUM_TEMPOS] = '{
		40, 60, 80, 100, 120, 140, 180, 220
	};

	////////////////////////////////////////////////////////////
	// seven segment patterns, gfedcba
	////////////////////////////////////////////////////////////
	localparam logic [SEG_W-1:0] SEG_TABLE [16] = '{
		7'b100_0000, 7'b111_1001, 7'b010_0100, 7'b011_0000,
		7'b001_1001, 7'b001_0010, 7'b000_0010, 7'b111_1000,
		7'b000_0000, 7'b001_1000, 7'b000_1000, 7'b000_0011,
		7'b100_0110, 7'b010_0001, 7'b000_0110, 7'b000_1110
	};

	////////////////////////////////////////////////////////////
	// mode controller states
	////////////////////////////////////////////////////////////
	typedef enum logic [3:0] {
		ST_SELECT        = 4'd0,
		ST_SELECT_REL    = 4'd1,
		ST_WAIT_REC      = 4'd2,
		ST_WAIT_REC_REL  = 4'd3,
		ST_RECORDING     = 4'd4,
		ST_RECORDING_REL = 4'd5,
		ST_REC_STOP      = 4'd6,
		ST_REC_STOP_REL  = 4'd7,
		ST_WAIT_PLAY     = 4'd8,
		ST_WAIT_PLAY_REL = 4'd9,
		ST_PLAYING       = 4'd10,
		ST_PLAYING_REL   = 4'd11,
		ST_PLAY_STOP     = 4'd12,
		ST_PLAY_STOP_REL = 4'd13
	} mode_state_t;

endpackage
